// ==== compile.f ====
logic/meas_cfg_pkg.sv
logic/meas_ctrl_pkg.sv
logic/measure_sequencer.sv
logic/window_timer.sv
logic/comparator_counter.sv
logic/measure_channel.sv
test/measure_channel_sva.sv
test/measure_channel_tb.sv

// ==== Makefile ====
# Verilator build and run of the measurement channel testbench

VERILATOR ?= verilator
TOP       ?= measure_channel_tb
FILE_LIST ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, search $(LOG) for the result"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILE_LIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)
	$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "Simulation PASSED" $(LOG) || (echo "Run did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== test/measure_channel_tb.sv ====
/*
 * Measurement channel testbench
 * Directed tests of reset, full and empty windows, a random comparator
 * pattern, the clock-enable freeze, start hold with restart and the
 * zero-length window. Expected results come from the counting rules.
 */

`timescale 1ns/1ps
`default_nettype none

module measure_channel_tb;

    localparam int CLOCK_PERIOD = 40;               // ns
    localparam int RESET_CYCLES = 8;
    localparam int PULSE_GAP    = 4;                // Cycles between pulses
    localparam int SEED         = 58188;
    localparam int SETUP_CYCLES = 12;               // Start, load, done and release margin
    localparam int TEST_CYCLES  = RESET_CYCLES + 2
                                + 2 * (5 * PULSE_GAP + SETUP_CYCLES)     // Full, empty
                                + (23 * PULSE_GAP + SETUP_CYCLES)        // Random
                                + (8 * PULSE_GAP + SETUP_CYCLES)         // Freeze
                                + 2 * (3 * PULSE_GAP + SETUP_CYCLES) + 6 // Restart
                                + (PULSE_GAP + SETUP_CYCLES);            // Zero length
    localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

    logic                 op_clock;
    logic                 reset;
    logic                 enable;
    logic                 start;
    logic                 pulse;
    logic                 cmp_in;
    meas_cfg_pkg::count_t window_length;
    logic                 busy;
    logic                 interrupt;
    logic                 ioff;
    meas_cfg_pkg::count_t result;

    int   error_count;
    int   check_count;
    int   irq_count;                                // Interrupt rising edges seen
    int   cycle_count;
    logic interrupt_prev;
    logic sample_q[$];                              // Comparator level per pulse

    measure_channel
    #(
        .IDAC_MODE (meas_cfg_pkg::IDAC_SOURCE)
    )
    i_measure_channel
    (
        .op_clock      (op_clock),
        .reset         (reset),
        .enable        (enable),
        .start         (start),
        .pulse         (pulse),
        .cmp_in        (cmp_in),
        .window_length (window_length),
        .busy          (busy),
        .interrupt     (interrupt),
        .ioff          (ioff),
        .result        (result)
    );

    bind measure_sequencer measure_channel_sva i_measure_channel_sva
    (
        .op_clock  (op_clock),
        .reset     (reset),
        .enable    (enable),
        .ctrl      (ctrl),
        .busy      (busy),
        .interrupt (interrupt)
    );

    always #(CLOCK_PERIOD / 2) op_clock = ~op_clock;

    // Count interrupts away from the active edge
    always @(negedge op_clock)
    begin
        if (interrupt && !interrupt_prev)
        begin
            irq_count++;
        end
        interrupt_prev = interrupt;
    end

    always @(posedge op_clock)
    begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES)
        begin
            $display("ERROR: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Checks run: %0d, errors: %0d", check_count, error_count + 1);
            $display("Simulation FAILED");
            $finish;
        end
    end

    // One enabled-or-not clock, inputs change 1 ns later
    task automatic tick;
        @(posedge op_clock);
        #1;
    endtask

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
        check_count++;
        assert (got === want)
        else
        begin
            $display("mismatch %s: got 0x%0h, expected 0x%0h", name, got, want);
            error_count++;
        end
    endtask

    // One-cycle pulse with the given comparator level
    task automatic drive_pulse(input logic sample);
        pulse  = 1'b1;
        cmp_in = sample;
        tick;
        pulse  = 1'b0;
        if (enable)
        begin
            compare_value("ioff", 32'(ioff), 32'(sample)); // Source mode keeps polarity
        end
    endtask

    task automatic pulse_gap;
        repeat (PULSE_GAP - 1) tick;
    endtask

    task automatic wait_interrupt(input int max_cycles);
        int   waited;
        logic seen;
        waited = 0;
        seen   = 1'b0;
        while (!seen && waited < max_cycles)
        begin
            tick;
            waited++;
            seen = interrupt;
        end
        check_count++;
        assert (seen)
        else
        begin
            $display("ERROR: interrupt not seen within %0d cycles", max_cycles);
            error_count++;
        end
    endtask

    // Raise start and wait until the sequencer sits in ST_WAIT_PULSE
    task automatic begin_window(input int len);
        int waited;
        window_length = meas_cfg_pkg::count_t'(len);
        start         = 1'b1;
        waited        = 0;
        while (!busy && waited < 4)
        begin
            tick;
            waited++;
        end
        check_count++;
        assert (busy)
        else
        begin
            $display("ERROR: busy did not rise after start");
            error_count++;
        end
        tick;                                       // Load edge
        compare_value("result after load", 32'(result), 32'(0));
    endtask

    task automatic release_start;
        start = 1'b0;
        tick;
        tick;                                       // Back in ST_IDLE
        compare_value("busy after release", 32'(busy), 32'(0));
    endtask

    // Window over sample_q, expected count is the number of low samples
    task automatic run_window(input int len, input string label);
        int n;
        int expected;
        int irq_before;
        n          = (len == 0) ? 1 : len;
        expected   = 0;
        irq_before = irq_count;
        begin_window(len);
        for (int i = 0; i < n; i++)
        begin
            drive_pulse(sample_q[i]);
            if (!sample_q[i])
            begin
                expected++;
            end
            if (i < n - 1)
            begin
                pulse_gap;
            end
            else
            begin
                wait_interrupt(2 * PULSE_GAP);
            end
        end
        tick;
        compare_value({label, " result"}, 32'(result), 32'(expected));
        compare_value({label, " busy"}, 32'(busy), 32'(0));
        compare_value({label, " interrupts"}, irq_count - irq_before, 1);
    endtask

    task automatic check_reset_state;
        compare_value("busy", 32'(busy), 32'(0));
        compare_value("interrupt", 32'(interrupt), 32'(0));
        compare_value("ioff", 32'(ioff), 32'(0));
        compare_value("result", 32'(result), 32'(0));
    endtask

    task automatic full_empty_windows;
        sample_q = {1'b0, 1'b0, 1'b0, 1'b0, 1'b0};
        run_window(5, "all low");
        release_start;
        sample_q = {1'b1, 1'b1, 1'b1, 1'b1, 1'b1};
        run_window(5, "all high");
        release_start;
    endtask

    task automatic random_pattern_window;
        logic [31:0] rnd;
        int          low_count;                     // Low samples in the window
        sample_q.delete();
        low_count = 0;
        for (int i = 0; i < 20; i++)
        begin
            rnd = $urandom();
            sample_q.push_back(rnd[0]);
            if (!rnd[0])
            begin
                low_count++;
            end
        end
        run_window(20, "random");
        for (int i = 0; i < 3; i++)                 // Extra pulses after done
        begin
            rnd = $urandom();
            drive_pulse(rnd[0]);
            pulse_gap;
            compare_value("result after extra pulse", 32'(result), 32'(low_count));
        end
        release_start;
    endtask

    task automatic enable_freeze;
        int irq_before;
        irq_before = irq_count;
        begin_window(5);
        for (int i = 0; i < 8; i++)
        begin
            if (i == 1 || i == 4 || i == 6)
            begin
                enable = 1'b0;                      // Pulse lands on a frozen edge
                drive_pulse(1'b0);
                enable = 1'b1;
                pulse_gap;
            end
            else if (i < 7)
            begin
                drive_pulse(1'b0);
                pulse_gap;
            end
            else
            begin
                compare_value("result before fifth pulse", 32'(result), 32'(4));
                compare_value("interrupts before fifth pulse", irq_count - irq_before, 0);
                compare_value("busy before fifth pulse", 32'(busy), 32'(1));
                drive_pulse(1'b0);
                wait_interrupt(2 * PULSE_GAP);
            end
        end
        tick;
        compare_value("frozen result", 32'(result), 32'(5));
        compare_value("frozen interrupts", irq_count - irq_before, 1);
        release_start;
    endtask

    task automatic start_hold_restart;
        int irq_after;
        sample_q = {1'b0, 1'b0, 1'b0};
        run_window(3, "hold");
        irq_after = irq_count;
        repeat (6)
        begin
            tick;
            compare_value("busy while held", 32'(busy), 32'(0));
            compare_value("result while held", 32'(result), 32'(3));
        end
        compare_value("interrupts while held", irq_count - irq_after, 0);
        release_start;
        compare_value("result in idle", 32'(result), 32'(3)); // Held until reload
        sample_q = {1'b1, 1'b0, 1'b1};
        run_window(3, "restart");
        release_start;
    endtask

    task automatic zero_length_window;
        sample_q = {1'b0};
        run_window(0, "zero length");
        release_start;
    endtask

    initial
    begin
        op_clock       = 1'b0;
        reset          = 1'b1;
        enable         = 1'b1;
        start          = 1'b0;
        pulse          = 1'b0;
        cmp_in         = 1'b0;
        window_length  = '0;
        error_count    = 0;
        check_count    = 0;
        irq_count      = 0;
        cycle_count    = 0;
        interrupt_prev = 1'b0;
        void'($urandom(SEED));                      // Seed once for the whole run
        repeat (RESET_CYCLES) tick;
        reset = 1'b0;

        check_reset_state;
        full_empty_windows;
        random_pattern_window;
        enable_freeze;
        start_hold_restart;
        zero_length_window;

        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
        begin
            $display("Simulation PASSED");
        end
        else
        begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule : measure_channel_tb

`default_nettype wire

// ==== test/measure_channel_sva.sv ====
/*
 * Sequencer protocol assertions
 * Bound into the window sequencer. Covers the one-cycle interrupt,
 * exclusive load and step commands, and busy low at interrupt time.
 */

`timescale 1ns/1ps
`default_nettype none

module measure_channel_sva
(
    input logic                     op_clock,
    input logic                     reset,
    input logic                     enable,         // Clock enable of the DUT
    input meas_ctrl_pkg::seq_ctrl_t ctrl,           // Sequencer command bus
    input logic                     busy,
    input logic                     interrupt
);

    // Interrupt register clears on the next enabled edge
    interrupt_one_cycle : assert property
    (
        @(posedge op_clock) disable iff (reset)
        (interrupt && enable) |=> !interrupt
    )
    else $error("interrupt high on two consecutive enabled cycles");

    // Load and step come from distinct states
    load_step_exclusive : assert property
    (
        @(posedge op_clock) disable iff (reset)
        !(ctrl.load && ctrl.step)
    )
    else $error("load and step commands high together");

    // Interrupt only in ST_DONE, where busy is low
    interrupt_not_busy : assert property
    (
        @(posedge op_clock) disable iff (reset)
        interrupt |-> !busy
    )
    else $error("busy high while interrupt is high");

endmodule : measure_channel_sva

`default_nettype wire

// ==== logic/measure_channel.sv ====
/*
 * Capacitive-sense measurement channel
 * Top level. The sequencer frames a window of sense pulses, the
 * window timer counts it down and the comparator counter totals the
 * active comparator samples inside it.
 */

`timescale 1ns/1ps
`default_nettype none

module measure_channel
#(
    parameter meas_cfg_pkg::idac_mode_e IDAC_MODE = meas_cfg_pkg::IDAC_SOURCE
)
(
    input  logic                 op_clock,
    input  logic                 reset,
    input  logic                 enable,              // Clock enable
    input  logic                 start,               // Measurement request level
    input  logic                 pulse,               // Sense clock strobe
    input  logic                 cmp_in,              // Comparator output
    input  meas_cfg_pkg::count_t window_length,       // Pulses per window
    output logic                 busy,
    output logic                 interrupt,           // End of window
    output logic                 ioff,                // Registered comparator
    output meas_cfg_pkg::count_t result
);

    meas_ctrl_pkg::seq_ctrl_t ctrl;                   // Load and step commands
    logic                     window_last;

    measure_sequencer i_measure_sequencer
    (
        .op_clock    (op_clock),
        .reset       (reset),
        .enable      (enable),
        .start       (start),
        .pulse       (pulse),
        .window_last (window_last),
        .ctrl        (ctrl),
        .busy        (busy),
        .interrupt   (interrupt)
    );

    window_timer i_window_timer
    (
        .op_clock      (op_clock),
        .reset         (reset),
        .enable        (enable),
        .ctrl          (ctrl),
        .window_length (window_length),
        .window_last   (window_last)
    );

    comparator_counter
    #(
        .IDAC_MODE (IDAC_MODE)
    )
    i_comparator_counter
    (
        .op_clock (op_clock),
        .reset    (reset),
        .enable   (enable),
        .pulse    (pulse),
        .cmp_in   (cmp_in),
        .ctrl     (ctrl),
        .ioff     (ioff),
        .result   (result)
    );

endmodule : measure_channel

`default_nettype wire

// ==== logic/comparator_counter.sv ====
/*
 * Comparator sampler and active-sample counter
 * Captures the comparator on each sense pulse with the polarity of
 * the IDAC mode, drives ioff from that sample, and counts active
 * samples on each window step. The count saturates at full scale.
 */

`timescale 1ns/1ps
`default_nettype none

module comparator_counter
#(
    parameter meas_cfg_pkg::idac_mode_e IDAC_MODE = meas_cfg_pkg::IDAC_SOURCE
)
(
    input  logic                     op_clock,
    input  logic                     reset,
    input  logic                     enable,          // Clock enable
    input  logic                     pulse,           // Sample strobe
    input  logic                     cmp_in,          // Raw comparator
    input  meas_ctrl_pkg::seq_ctrl_t ctrl,
    output logic                     ioff,            // Registered sample
    output meas_cfg_pkg::count_t     result           // Active samples in window
);

    logic sample_in;                                  // Comparator after polarity fix
    logic sample_active;                              // Held sample counts this step
    logic result_full;

    // Sink mode flips the comparator so that ioff low always means active
    assign sample_in = (IDAC_MODE == meas_cfg_pkg::IDAC_SINK) ? ~cmp_in : cmp_in;

    always_ff @(posedge op_clock)
    begin
        if (reset)
        begin
            ioff <= 1'b0;
        end
        else if (enable && pulse)
        begin
            ioff <= sample_in;
        end
    end

    // Step comes one cycle after the pulse, so ioff holds that pulse's sample
    assign sample_active = ~ioff;
    assign result_full   = (result == meas_cfg_pkg::COUNT_MAX);

    always_ff @(posedge op_clock)
    begin
        if (reset)
        begin
            result <= '0;
        end
        else if (enable)
        begin
            if (ctrl.load)
            begin
                result <= '0;                         // New measurement
            end
            else if (ctrl.step && sample_active && !result_full)
            begin
                result <= result + meas_cfg_pkg::COUNT_ONE;
            end
        end
    end

endmodule : comparator_counter

`default_nettype wire

// ==== logic/window_timer.sv ====
/*
 * Window down-counter
 * Loads the window length on a load command, with zero taken as one,
 * counts down on each step and flags the last pulse of the window.
 */

`timescale 1ns/1ps
`default_nettype none

module window_timer
(
    input  logic                     op_clock,
    input  logic                     reset,
    input  logic                     enable,          // Clock enable
    input  meas_ctrl_pkg::seq_ctrl_t ctrl,
    input  meas_cfg_pkg::count_t     window_length,   // Pulses per window
    output logic                     window_last      // One pulse left
);

    meas_cfg_pkg::count_t remaining;                  // Pulses still to go
    meas_cfg_pkg::count_t load_value;

    // Empty window not allowed, run a single pulse instead
    assign load_value = (window_length == '0) ? meas_cfg_pkg::COUNT_ONE
                                              : window_length;

    always_ff @(posedge op_clock)
    begin
        if (reset)
        begin
            remaining <= '0;
        end
        else if (enable)
        begin
            if (ctrl.load)
            begin
                remaining <= load_value;
            end
            else if (ctrl.step)
            begin
                remaining <= remaining - meas_cfg_pkg::COUNT_ONE; // Never below zero in use
            end
        end
    end

    // Checked during ST_COUNT, before this step's decrement lands
    assign window_last = (remaining == meas_cfg_pkg::COUNT_ONE);

endmodule : window_timer

`default_nettype wire

// ==== logic/measure_sequencer.sv ====
/*
 * Measurement window sequencer
 * Walks idle, load, wait, count and done. Issues one load per
 * measurement and one step per counted pulse, and raises a
 * one-cycle interrupt on entry to the done state.
 */

`timescale 1ns/1ps
`default_nettype none

module measure_sequencer
(
    input  logic                    op_clock,
    input  logic                    reset,
    input  logic                    enable,           // Clock enable for all registers
    input  logic                    start,            // Level request
    input  logic                    pulse,            // One-cycle sense strobe
    input  logic                    window_last,      // Remaining window is one pulse
    output meas_ctrl_pkg::seq_ctrl_t ctrl,
    output logic                    busy,
    output logic                    interrupt
);

    meas_ctrl_pkg::seq_state_e state;
    meas_ctrl_pkg::seq_state_e state_next;
    logic                      close_window;          // Final pulse of the window

    // The step cycle is also the cycle that decides whether the window ends
    assign close_window = (state == meas_ctrl_pkg::ST_COUNT) && window_last;

    always_comb
    begin
        state_next = state;                           // Hold by default
        case (state)
            meas_ctrl_pkg::ST_IDLE:
            begin
                if (start)
                begin
                    state_next = meas_ctrl_pkg::ST_LOAD;
                end
            end
            meas_ctrl_pkg::ST_LOAD:
            begin
                state_next = meas_ctrl_pkg::ST_WAIT_PULSE; // Always one cycle
            end
            meas_ctrl_pkg::ST_WAIT_PULSE:
            begin
                if (pulse)
                begin
                    state_next = meas_ctrl_pkg::ST_COUNT;  // Sample lands in ioff here
                end
            end
            meas_ctrl_pkg::ST_COUNT:
            begin
                if (window_last)
                begin
                    state_next = meas_ctrl_pkg::ST_DONE;
                end
                else
                begin
                    state_next = meas_ctrl_pkg::ST_WAIT_PULSE;
                end
            end
            meas_ctrl_pkg::ST_DONE:
            begin
                if (!start)
                begin
                    state_next = meas_ctrl_pkg::ST_IDLE;   // Result held until reload
                end
            end
            default:
            begin
                state_next = meas_ctrl_pkg::ST_IDLE;       // Recover from unused codes
            end
        endcase
    end

    always_ff @(posedge op_clock)
    begin
        if (reset)
        begin
            state     <= meas_ctrl_pkg::ST_IDLE;
            interrupt <= 1'b0;
        end
        else if (enable)
        begin
            state     <= state_next;
            interrupt <= close_window;                // High for first ST_DONE cycle only
        end
    end

    // Command decode
    assign ctrl.load = (state == meas_ctrl_pkg::ST_LOAD);
    assign ctrl.step = (state == meas_ctrl_pkg::ST_COUNT);

    assign busy = (state == meas_ctrl_pkg::ST_LOAD)
               || (state == meas_ctrl_pkg::ST_WAIT_PULSE)
               || (state == meas_ctrl_pkg::ST_COUNT);

endmodule : measure_sequencer

`default_nettype wire

// ==== logic/meas_ctrl_pkg.sv ====
/*
 * Measurement channel control package
 * Sequencer state encoding and the command bus that the sequencer
 * drives into the window timer and the comparator counter.
 */

`default_nettype none

package meas_ctrl_pkg;

    // Window sequencer states
    typedef enum logic [2:0]
    {
        ST_IDLE       = 3'd0,                           // Waiting for start
        ST_LOAD       = 3'd1,                           // Load window, clear result
        ST_WAIT_PULSE = 3'd2,                           // Waiting for next sense pulse
        ST_COUNT      = 3'd3,                           // Step window, count sample
        ST_DONE       = 3'd4                            // Window closed, result held
    } seq_state_e;

    // Commands from sequencer to datapath
    // At most one bit is high in any cycle
    typedef struct packed
    {
        logic load;                                     // Clear result, load window length
        logic step;                                     // Advance window by one pulse
    } seq_ctrl_t;

endpackage : meas_ctrl_pkg

`default_nettype wire

// ==== logic/meas_cfg_pkg.sv ====
/*
 * Measurement channel configuration package
 * Counter width, the shared count type and the current-source mode
 * that sets which comparator level counts as an active sample.
 */

`default_nettype none

package meas_cfg_pkg;

    localparam int COUNT_WIDTH = 16;                    // Window and result counters

    // Window length, remaining window and result all share this type
    typedef logic [COUNT_WIDTH-1:0] count_t;

    localparam count_t COUNT_MAX = '1;                  // Saturation point of result
    localparam count_t COUNT_ONE = count_t'(1);         // Last-pulse marker, zero remap

    // IDAC current direction
    // Source mode counts a low comparator, sink mode a high one
    typedef enum logic
    {
        IDAC_SOURCE = 1'b0,                             // Low sample is active
        IDAC_SINK   = 1'b1                              // High sample is active
    } idac_mode_e;

endpackage : meas_cfg_pkg

`default_nettype wire
